//--- Bender.yml
package:
  name: bishop_eval

sources:
  - include_dirs:
      - common
    files:
      - common/chess_eval_pkg.sv
      - design/popcount.sv
      - design/latency_sm.sv
      - bishop_eval/bishop_weights.sv
      - bishop_eval/bishop_eval.sv
      - design/eval_combine.sv
      - design/bishop_eval_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/bishop_eval_tb.sv

//--- bishop_eval/bishop_eval.sv
// Seven-stage bishop scorer for one color
// Board and weights must stay stable until side_valid
`timescale 1ns/1ps
`include "chess_eval_cfg.svh"
`default_nettype none

module bishop_eval
   import chess_eval_pkg::*;
#(
   parameter bit WHITE_SIDE = 1'b1
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            board_valid,
   input  logic            clear_eval,
   input  board_t          board,
   input  bishop_weights_t weights,
   output score_t          score,
   output logic            side_valid
);

   localparam int EW = `CHESS_EVAL_WIDTH;
   localparam piece_e OWN_BISHOP = WHITE_SIDE ? WHITE_BISHOP : BLACK_BISHOP;
   localparam piece_e OWN_PAWN   = WHITE_SIDE ? WHITE_PAWN : BLACK_PAWN;

   logic [63:0]          bish_mask_t1;
   logic [63:0]          pawn_w_mask_t1, pawn_b_mask_t1; // Own pawns by square color
   logic [6:0]           bish_cnt_t2;
   logic [6:0]           pawn_w_cnt_t2, pawn_b_cnt_t2;
   logic [5:0]           lone_sq_t2;
   logic [6:0]           pawn_w_cnt_t3, pawn_b_cnt_t3;
   logic                 lone_white_t3, single_t3;
   logic signed [EW-1:0] pair_mg_t3, pair_eg_t3;
   logic [6:0]           tpawns_t4;
   logic signed [EW-1:0] pair_mg_t4, pair_eg_t4;
   logic signed [EW-1:0] pen_mg_t5, pen_eg_t5;
   logic signed [EW-1:0] pair_mg_t5, pair_eg_t5;
   logic signed [EW-1:0] side_mg_t6, side_eg_t6;

   // Stage 1, square masks
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 64; i++)
      begin
         bish_mask_t1[i] <= (board[i] == OWN_BISHOP);
         if (((i >> 3) & 1) != (i & 1)) // Light square
         begin
            pawn_w_mask_t1[i] <= (board[i] == OWN_PAWN);
            pawn_b_mask_t1[i] <= 1'b0;
         end
         else
         begin
            pawn_w_mask_t1[i] <= 1'b0;
            pawn_b_mask_t1[i] <= (board[i] == OWN_PAWN);
         end
      end
   end

   // Stage 2, counts land from the popcounts
   popcount bish_cnt_i   (.clk, .rst_n, .bits(bish_mask_t1),   .count(bish_cnt_t2));
   popcount pawn_w_cnt_i (.clk, .rst_n, .bits(pawn_w_mask_t1), .count(pawn_w_cnt_t2));
   popcount pawn_b_cnt_i (.clk, .rst_n, .bits(pawn_b_mask_t1), .count(pawn_b_cnt_t2));

   // Any set square, only meaningful for a single bishop
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 64; i++)
         if (bish_mask_t1[i])
            lone_sq_t2 <= 6'(i);
   end

   // Stages 3 to 7, bonus and penalty arithmetic
   always_ff @(posedge clk)
   begin
      pair_mg_t3    <= (bish_cnt_t2 >= 7'd2) ? EW'(weights.pair_mg) : '0;
      pair_eg_t3    <= (bish_cnt_t2 >= 7'd2) ? EW'(weights.pair_eg) : '0;
      pawn_w_cnt_t3 <= pawn_w_cnt_t2;
      pawn_b_cnt_t3 <= pawn_b_cnt_t2;
      lone_white_t3 <= lone_sq_t2[3] != lone_sq_t2[0];
      single_t3     <= bish_cnt_t2 == 7'd1;

      if (single_t3)
         tpawns_t4 <= lone_white_t3 ? pawn_w_cnt_t3 : pawn_b_cnt_t3;
      else
         tpawns_t4 <= '0; // No pair or no bishop, no penalty
      pair_mg_t4 <= pair_mg_t3;
      pair_eg_t4 <= pair_eg_t3;

      pen_mg_t5  <= EW'(tpawns_t4 * weights.tpawn_mg); // At most 32 * 255
      pen_eg_t5  <= EW'(tpawns_t4 * weights.tpawn_eg);
      pair_mg_t5 <= pair_mg_t4;
      pair_eg_t5 <= pair_eg_t4;

      side_mg_t6 <= pair_mg_t5 - pen_mg_t5;
      side_eg_t6 <= pair_eg_t5 - pen_eg_t5;

      if (WHITE_SIDE)
      begin
         score.mg <= side_mg_t6;
         score.eg <= side_eg_t6;
      end
      else
      begin
         score.mg <= -side_mg_t6; // Black counts against
         score.eg <= -side_eg_t6;
      end
   end

   latency_sm #(
      .LATENCY(`CHESS_BISHOP_LATENCY)
   ) latency_i (
      .clk,
      .rst_n,
      .board_valid,
      .clear_eval,
      .eval_valid(side_valid)
   );

endmodule

`default_nettype wire

//--- bishop_eval/bishop_weights.sv
// Host-writable bishop weights, shared by both colors
// A write is visible to the scorers from the next clock
`timescale 1ns/1ps
`include "chess_eval_cfg.svh"
`default_nettype none

module bishop_weights
   import chess_eval_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           cfg_we,
   input  weight_addr_e                   cfg_addr,
   input  logic [`CHESS_WEIGHT_WIDTH-1:0] cfg_wdata,
   output bishop_weights_t                weights
);

   localparam int WW = `CHESS_WEIGHT_WIDTH;

   // Tuned defaults
   localparam bishop_weights_t WEIGHTS_RST = '{
      pair_mg:  WW'(`CHESS_PAIR_MG_RST),
      pair_eg:  WW'(`CHESS_PAIR_EG_RST),
      tpawn_mg: WW'(`CHESS_TPAWN_MG_RST),
      tpawn_eg: WW'(`CHESS_TPAWN_EG_RST)
   };

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         weights <= WEIGHTS_RST;
      else if (cfg_we)
      begin
         case (cfg_addr)
            WADDR_PAIR_MG:
               weights.pair_mg <= cfg_wdata;
            WADDR_PAIR_EG:
               weights.pair_eg <= cfg_wdata;
            WADDR_TPAWN_MG:
               weights.tpawn_mg <= cfg_wdata;
            WADDR_TPAWN_EG:
               weights.tpawn_eg <= cfg_wdata;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- bishop_eval_top.f
+incdir+common
common/chess_eval_pkg.sv
design/popcount.sv
design/latency_sm.sv
bishop_eval/bishop_weights.sv
bishop_eval/bishop_eval.sv
design/eval_combine.sv
design/bishop_eval_top.sv
test/bishop_eval_tb.sv

//--- common/chess_eval_cfg.svh
// Widths and latencies shared by the bishop evaluator
// Weight reset values assume an 8-bit unsigned weight
`ifndef CHESS_EVAL_CFG_SVH
`define CHESS_EVAL_CFG_SVH

// Bits per board square
`define CHESS_PIECE_WIDTH 4

// Signed score field width
`define CHESS_EVAL_WIDTH 16

// Unsigned host weight width
`define CHESS_WEIGHT_WIDTH 8

// Cycles from board_valid to one side's score
`define CHESS_BISHOP_LATENCY 7

// Weight values after reset
`define CHESS_PAIR_MG_RST 38
`define CHESS_PAIR_EG_RST 56
`define CHESS_TPAWN_MG_RST 4
`define CHESS_TPAWN_EG_RST 6

`endif

//--- common/chess_eval_pkg.sv
// Types for the bishop evaluator
// Black piece codes are the white code with bit 3 set
`include "chess_eval_cfg.svh"
`default_nettype none

package chess_eval_pkg;

   // Square contents
   typedef enum logic [`CHESS_PIECE_WIDTH-1:0] {
      EMPTY        = 4'h0,
      WHITE_PAWN   = 4'h1,
      WHITE_KNIGHT = 4'h2,
      WHITE_BISHOP = 4'h3,
      WHITE_ROOK   = 4'h4,
      WHITE_QUEEN  = 4'h5,
      WHITE_KING   = 4'h6,
      BLACK_PAWN   = 4'h9,
      BLACK_KNIGHT = 4'ha,
      BLACK_BISHOP = 4'hb,
      BLACK_ROOK   = 4'hc,
      BLACK_QUEEN  = 4'hd,
      BLACK_KING   = 4'he
   } piece_e;

   // Index is row * 8 + column
   typedef piece_e [63:0] board_t;

   typedef struct packed {
      logic signed [`CHESS_EVAL_WIDTH-1:0] mg; // Midgame term
      logic signed [`CHESS_EVAL_WIDTH-1:0] eg; // Endgame term
   } score_t;

   typedef struct packed {
      logic [`CHESS_WEIGHT_WIDTH-1:0] pair_mg;
      logic [`CHESS_WEIGHT_WIDTH-1:0] pair_eg;
      logic [`CHESS_WEIGHT_WIDTH-1:0] tpawn_mg; // Per pawn on the bishop's color
      logic [`CHESS_WEIGHT_WIDTH-1:0] tpawn_eg;
   } bishop_weights_t;

   // Host register select
   typedef enum logic [1:0] {
      WADDR_PAIR_MG  = 2'd0,
      WADDR_PAIR_EG  = 2'd1,
      WADDR_TPAWN_MG = 2'd2,
      WADDR_TPAWN_EG = 2'd3
   } weight_addr_e;

endpackage

`default_nettype wire

//--- design/bishop_eval_top.sv
// Bishop evaluation for both colors with a host weight port
// Hold board and weights stable from board_valid until eval_valid
`timescale 1ns/1ps
`include "chess_eval_cfg.svh"
`default_nettype none

module bishop_eval_top
   import chess_eval_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           board_valid,
   input  logic                           clear_eval,
   input  logic                           cfg_we,
   input  weight_addr_e                   cfg_addr,
   input  logic [`CHESS_WEIGHT_WIDTH-1:0] cfg_wdata,
   input  board_t                         board,
   output score_t                         eval,
   output logic                           eval_valid
);

   bishop_weights_t weights;
   score_t          white_score, black_score;
   logic            white_valid, black_valid;

   bishop_weights weights_i (
      .clk,
      .rst_n,
      .cfg_we,
      .cfg_addr,
      .cfg_wdata,
      .weights
   );

   bishop_eval #(
      .WHITE_SIDE(1'b1)
   ) white_i (
      .clk,
      .rst_n,
      .board_valid,
      .clear_eval,
      .board,
      .weights,
      .score     (white_score),
      .side_valid(white_valid)
   );

   bishop_eval #(
      .WHITE_SIDE(1'b0)
   ) black_i (
      .clk,
      .rst_n,
      .board_valid,
      .clear_eval,
      .board,
      .weights,
      .score     (black_score),
      .side_valid(black_valid)
   );

   eval_combine combine_i (
      .clk,
      .rst_n,
      .clear_eval,
      .white_score,
      .black_score,
      .white_valid,
      .black_valid,
      .eval,
      .eval_valid
   );

endmodule

`default_nettype wire

//--- design/eval_combine.sv
// Adds the white and black bishop scores
// Both sides must share one latency, so their valids agree
`timescale 1ns/1ps
`include "chess_eval_cfg.svh"
`default_nettype none

module eval_combine
   import chess_eval_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   clear_eval,
   input  score_t white_score,
   input  score_t black_score,
   input  logic   white_valid,
   input  logic   black_valid,
   output score_t eval,
   output logic   eval_valid
);

   // Black fields already carry their sign
   always_ff @(posedge clk)
   begin
      eval.mg <= white_score.mg + black_score.mg;
      eval.eg <= white_score.eg + black_score.eg;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         eval_valid <= 1'b0;
      else if (clear_eval)
         eval_valid <= 1'b0;
      else
         eval_valid <= white_valid; // One cycle behind the sum inputs
   end

   // The two scorers run in lockstep
   a_sides_agree : assert property (
      @(posedge clk) disable iff (!rst_n)
      white_valid == black_valid
   ) else $error("white_valid and black_valid disagree");

endmodule

`default_nettype wire

//--- design/latency_sm.sv
// Valid tracker for a fixed-latency pipeline
// A new board_valid restarts the count and drops eval_valid
`timescale 1ns/1ps
`default_nettype none

module latency_sm #(
   parameter int LATENCY = 7
) (
   input  logic clk,
   input  logic rst_n,
   input  logic board_valid,
   input  logic clear_eval,
   output logic eval_valid
);

   localparam int CNT_W = $clog2(LATENCY + 1);

   logic [CNT_W-1:0] cnt; // Cycles left, zero when idle

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt        <= '0;
         eval_valid <= 1'b0;
      end
      else if (board_valid)
      begin
         cnt        <= CNT_W'(LATENCY);
         eval_valid <= 1'b0; // Restart drops any old result
      end
      else
      begin
         if (cnt != '0)
            cnt <= cnt - 1'b1;
         if (clear_eval)
            eval_valid <= 1'b0;
         else if (cnt == CNT_W'(1))
            eval_valid <= 1'b1; // Last stage just loaded
      end
   end

   // Valid only once the full latency has elapsed
   a_no_early_valid : assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(eval_valid) |-> $past(board_valid, LATENCY + 1)
   ) else $error("eval_valid rose before the full latency after board_valid");

endmodule

`default_nettype wire

//--- design/popcount.sv
// Population count of a 64-bit mask
// Result follows the input by one clock
`timescale 1ns/1ps
`default_nettype none

module popcount (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [63:0] bits,
   output logic [6:0]  count
);

   logic [3:0] byte_cnt [8]; // Per byte, 0 to 8
   logic [4:0] half_cnt [4];
   logic [5:0] quad_cnt [2];
   logic [6:0] sum;

   always_comb
   begin
      for (int b = 0; b < 8; b++)
      begin
         byte_cnt[b] = '0;
         for (int k = 0; k < 8; k++)
            byte_cnt[b] = byte_cnt[b] + 4'(bits[b * 8 + k]);
      end
      for (int h = 0; h < 4; h++)
         half_cnt[h] = 5'(byte_cnt[2 * h]) + 5'(byte_cnt[2 * h + 1]);
      for (int q = 0; q < 2; q++)
         quad_cnt[q] = 6'(half_cnt[2 * q]) + 6'(half_cnt[2 * q + 1]);
      sum = 7'(quad_cnt[0]) + 7'(quad_cnt[1]);
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         count <= '0;
      else
         count <= sum;
   end

endmodule

`default_nettype wire

//--- test/bishop_eval_tb.sv
// Table-driven testbench for the bishop evaluator, fixed cases then chained random boards
// Expected values come from the scoring rules with the default or written weights
`timescale 1ns/1ps
`include "chess_eval_cfg.svh"
`default_nettype none

module bishop_eval_tb
   import chess_eval_pkg::*;
();

   localparam int CLK_PERIOD    = 8;
   localparam int RESET_CYCLES  = 8;
   localparam int N_FIXED       = 11;
   localparam int N_RANDOM      = 20;
   localparam int N_ENTRIES     = N_FIXED + N_RANDOM;
   localparam int VALID_TIMEOUT = 20;
   localparam int EXP_LATENCY   = 8; // Scorer plus combiner
   localparam int EW            = `CHESS_EVAL_WIDTH;
   localparam int WW            = `CHESS_WEIGHT_WIDTH;

   localparam bishop_weights_t DEFAULT_W = '{
      pair_mg:  WW'(38),
      pair_eg:  WW'(56),
      tpawn_mg: WW'(4),
      tpawn_eg: WW'(6)
   };

   typedef struct packed {
      logic            do_reset;
      logic            chain;    // Board enters together with the previous clear_eval
      logic            wr_en;
      weight_addr_e    wr_addr;
      logic [WW-1:0]   wr_data;
      board_t          board;
      score_t          exp;
   } entry_t;

   logic                  clk;
   logic                  rst_n;
   logic                  board_valid;
   logic                  clear_eval;
   logic                  cfg_we;
   weight_addr_e          cfg_addr;
   logic [WW-1:0]         cfg_wdata;
   board_t                board;
   score_t                eval;
   logic                  eval_valid;

   entry_t tbl [N_ENTRIES];
   int     n_built;
   int     errors;
   int     passed;
   integer seed;

   bishop_eval_top dut_i (
      .clk,
      .rst_n,
      .board_valid,
      .clear_eval,
      .cfg_we,
      .cfg_addr,
      .cfg_wdata,
      .board,
      .eval,
      .eval_valid
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Entries run about a dozen cycles each
   initial
   begin
      #((N_ENTRIES * 20 + RESET_CYCLES) * CLK_PERIOD);
      $display("watchdog expired before the last test finished");
      $display("tests failed");
      $finish;
   end

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic store_entry(input logic rst, input logic chain, input logic we,
                              input weight_addr_e addr, input int data,
                              input int mg, input int eg);
      tbl[n_built]          = '0;
      tbl[n_built].do_reset = rst;
      tbl[n_built].chain    = chain;
      tbl[n_built].wr_en    = we;
      tbl[n_built].wr_addr  = addr;
      tbl[n_built].wr_data  = WW'(data);
      tbl[n_built].exp.mg   = EW'(mg);
      tbl[n_built].exp.eg   = EW'(eg);
      n_built++;
   endtask

   task automatic new_board(input int mg, input int eg);
      store_entry(1'b0, 1'b0, 1'b0, WADDR_PAIR_MG, 0, mg, eg);
   endtask

   task automatic board_after_write(input weight_addr_e addr, input int data,
                                    input int mg, input int eg);
      store_entry(1'b0, 1'b0, 1'b1, addr, data, mg, eg);
   endtask

   task automatic put(input int sq, input piece_e pc);
      tbl[n_built - 1].board[sq] = pc;
   endtask

   // Three white pawns on light squares, two on dark
   task automatic place_lone_bishop(input int sq);
      put(sq, WHITE_BISHOP);
      put(8, WHITE_PAWN);
      put(10, WHITE_PAWN);
      put(12, WHITE_PAWN);
      put(9, WHITE_PAWN);
      put(11, WHITE_PAWN);
   endtask

   task automatic drop_pieces(input piece_e pc, input int n);
      int sq;
      for (int k = 0; k < n; k++)
      begin
         do
            sq = $unsigned($random(seed)) % 64;
         while (tbl[n_built - 1].board[sq] != EMPTY);
         put(sq, pc);
      end
   endtask

   // Pair bonus for two or more bishops, else pawn penalty for a lone bishop
   function automatic score_t ref_score(input board_t b, input bishop_weights_t w);
      int     mg, eg, nb, tp, light_pawns, dark_pawns, term_mg, term_eg;
      bit     light, lone_light;
      piece_e own_b, own_p;
      score_t r;
      mg = 0;
      eg = 0;
      for (int s = 0; s < 2; s++)
      begin
         own_b       = (s == 0) ? WHITE_BISHOP : BLACK_BISHOP;
         own_p       = (s == 0) ? WHITE_PAWN : BLACK_PAWN;
         nb          = 0;
         light_pawns = 0;
         dark_pawns  = 0;
         lone_light  = 1'b0;
         for (int sq = 0; sq < 64; sq++)
         begin
            light = ((sq / 8) % 2) != ((sq % 8) % 2);
            if (b[sq] == own_b)
            begin
               nb++;
               lone_light = light;
            end
            if (b[sq] == own_p && light)
               light_pawns++;
            else if (b[sq] == own_p)
               dark_pawns++;
         end
         term_mg = 0;
         term_eg = 0;
         if (nb >= 2)
         begin
            term_mg = int'(w.pair_mg);
            term_eg = int'(w.pair_eg);
         end
         else if (nb == 1)
         begin
            tp      = lone_light ? light_pawns : dark_pawns;
            term_mg = -tp * int'(w.tpawn_mg);
            term_eg = -tp * int'(w.tpawn_eg);
         end
         mg += (s == 0) ? term_mg : -term_mg;
         eg += (s == 0) ? term_eg : -term_eg;
      end
      r.mg = EW'(mg);
      r.eg = EW'(eg);
      return r;
   endfunction

   task automatic build_table();
      new_board(0, 0);
      new_board(0, 0); // Kings, pawns and officers but no bishops
      put(4, WHITE_KING);
      put(60, BLACK_KING);
      put(12, WHITE_PAWN);
      put(52, BLACK_PAWN);
      put(1, WHITE_KNIGHT);
      put(57, BLACK_ROOK);
      put(3, WHITE_QUEEN);
      new_board(38, 56);
      put(2, WHITE_BISHOP);
      put(5, WHITE_BISHOP);
      new_board(-38, -56);
      put(58, BLACK_BISHOP);
      put(61, BLACK_BISHOP);
      new_board(0, 0);
      put(2, WHITE_BISHOP);
      put(5, WHITE_BISHOP);
      put(58, BLACK_BISHOP);
      put(61, BLACK_BISHOP);
      new_board(-12, -18);
      place_lone_bishop(1); // Light square
      new_board(-8, -12);
      place_lone_bishop(2);
      board_after_write(WADDR_PAIR_MG, 50, 50, 56);
      put(2, WHITE_BISHOP);
      put(5, WHITE_BISHOP);
      board_after_write(WADDR_TPAWN_EG, 10, -12, -30);
      place_lone_bishop(1);
      new_board(-8, -20);
      place_lone_bishop(2);
      store_entry(1'b1, 1'b0, 1'b0, WADDR_PAIR_MG, 0, 38, 56); // Defaults back after reset
      put(2, WHITE_BISHOP);
      put(5, WHITE_BISHOP);
      for (int k = 0; k < N_RANDOM; k++)
      begin
         store_entry(1'b0, 1'b1, 1'b0, WADDR_PAIR_MG, 0, 0, 0);
         drop_pieces(WHITE_KING, 1);
         drop_pieces(BLACK_KING, 1);
         drop_pieces(WHITE_BISHOP, $unsigned($random(seed)) % 4);
         drop_pieces(BLACK_BISHOP, $unsigned($random(seed)) % 4);
         drop_pieces(WHITE_PAWN, $unsigned($random(seed)) % 9);
         drop_pieces(BLACK_PAWN, $unsigned($random(seed)) % 9);
         drop_pieces(BLACK_KNIGHT, $unsigned($random(seed)) % 3);
         tbl[n_built - 1].exp = ref_score(tbl[n_built - 1].board, DEFAULT_W);
      end
   endtask

   task automatic check_score(input score_t got, input score_t exp);
      if (got.mg !== exp.mg)
      begin
         $display("mismatch eval_mg: got 0x%h expected 0x%h", got.mg, exp.mg);
         errors++;
      end
      if (got.eg !== exp.eg)
      begin
         $display("mismatch eval_eg: got 0x%h expected 0x%h", got.eg, exp.eg);
         errors++;
      end
   endtask

   task automatic check_valid(input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("mismatch eval_valid: got 0x%h expected 0x%h", got, exp);
         errors++;
      end
   endtask

   task automatic check_latency(input int got);
      if (got != EXP_LATENCY)
      begin
         $display("mismatch eval_valid latency: got 0x%0h cycles expected 0x%0h",
                  got, EXP_LATENCY);
         errors++;
      end
   endtask

   task automatic run_entry(input int i);
      entry_t e;
      int     cycles;
      int     errs_before;
      e           = tbl[i];
      errs_before = errors;
      if (e.do_reset)
      begin
         rst_n = 1'b0;
         repeat (RESET_CYCLES) step();
         rst_n = 1'b1;
         step();
      end
      board       = e.board;
      board_valid = 1'b1;
      clear_eval  = e.chain; // Clears the previous result on the same edge
      cfg_we      = e.wr_en;
      cfg_addr    = e.wr_addr;
      cfg_wdata   = e.wr_data;
      step();
      board_valid = 1'b0;
      clear_eval  = 1'b0;
      cfg_we      = 1'b0;
      check_valid(eval_valid, 1'b0);
      cycles = 0;
      while (!eval_valid && cycles < VALID_TIMEOUT)
      begin
         step();
         cycles++;
      end
      if (!eval_valid)
      begin
         $display("eval_valid never rose within %0d cycles of board_valid", VALID_TIMEOUT);
         errors++;
      end
      else
      begin
         check_latency(cycles);
         check_score(eval, e.exp);
      end
      if (i + 1 == N_ENTRIES || !tbl[i + 1].chain)
      begin
         step();
         check_valid(eval_valid, 1'b1); // Result persists until cleared
         clear_eval = 1'b1;
         step();
         clear_eval = 1'b0;
         check_valid(eval_valid, 1'b0);
      end
      if (errors == errs_before)
         passed++;
      $display("test %0d %s: eval mg %0d eg %0d", i,
               (errors == errs_before) ? "ok" : "bad", eval.mg, eval.eg);
   endtask

   initial
   begin
      seed        = 32'h42a873f2;
      errors      = 0;
      passed      = 0;
      n_built     = 0;
      rst_n       = 1'b0;
      board_valid = 1'b0;
      clear_eval  = 1'b0;
      cfg_we      = 1'b0;
      cfg_addr    = WADDR_PAIR_MG;
      cfg_wdata   = '0;
      board       = '0;
      build_table();
      repeat (RESET_CYCLES) step();
      rst_n = 1'b1;
      step();
      for (int i = 0; i < N_ENTRIES; i++)
         run_entry(i);
      $display("%0d of %0d tests ok, %0d errors", passed, N_ENTRIES, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire
